// File: src/rp_pkg.sv
// Shared definitions for the ADC/DAC signal path
// Width constants, vector types, system bus structs
// Region and register map, slope conversion helper

`default_nettype none

package rp_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int SMP_W      = 14;  // ADC/DAC sample
  localparam int RB_W       = 16;  // RadioBox word
  localparam int PIN_W      = 16;  // ADC pin bus, two LSBs reserved
  localparam int LED_W      = 8;
  localparam int REGION_LSB = 20;  // Region field starts here
  localparam int REGION_CNT = 8;
  localparam int REGION_W   = $clog2(REGION_CNT);  // Bits 22..20

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  typedef logic        [PIN_W-1:0] adc_pins_t;  // Raw pin word
  typedef logic signed [SMP_W-1:0] sample_t;    // Two's complement
  typedef logic        [SMP_W-1:0] dac_code_t;  // Negative slope code
  typedef logic signed [SMP_W:0]   mix_sum_t;   // One guard bit
  typedef logic signed [RB_W-1:0]  rb_word_t;
  typedef logic        [LED_W-1:0] led_t;
  typedef logic        [31:0]      bus_word_t;

  // System bus, plain strobes, full-word writes
  typedef struct packed {
    bus_word_t addr;
    bus_word_t wdata;
    logic      wen;   // One-cycle pulse
    logic      ren;   // One-cycle pulse
  } sys_req_t;

  typedef struct packed {
    bus_word_t rdata;
    logic      ack;   // One cycle after the request
  } sys_rsp_t;

  // ----------------------------------------------------------
  // Register map, offsets within a region
  // ----------------------------------------------------------
  localparam int REGION_HK = 0;  // Housekeeping
  localparam int REGION_RB = 1;  // RadioBox and ADC readback

  localparam logic [REGION_LSB-1:0] HK_ID_OFS   = 20'h0_0000;  // RO
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS = 20'h0_0004;  // Bit 0 digital loop
  localparam logic [REGION_LSB-1:0] HK_LED_OFS  = 20'h0_0008;
  localparam bus_word_t             HK_ID_VALUE = 32'h5250_0001;

  localparam logic [REGION_LSB-1:0] RB_CTRL_OFS = 20'h0_0000;  // Activate, LED enable
  localparam logic [REGION_LSB-1:0] RB_LED_OFS  = 20'h0_0004;
  localparam logic [REGION_LSB-1:0] RB_ADC_OFS  = 20'h0_0008;  // RO, {B, A}

  // Negative slope <-> two's complement, same bit operation both ways
  function automatic logic [SMP_W-1:0] slope_flip(input logic [SMP_W-1:0] v);
    return {v[SMP_W-1], ~v[SMP_W-2:0]};  // Keep MSB, invert the rest
  endfunction

endpackage

`default_nettype wire

// File: src/dac_mixer.sv
// DAC mixing for both channels
// Generator plus regulator in 15 bits, saturated back to 14

`timescale 1ns/10ps
`default_nettype none

module dac_mixer (
  input  wire rp_pkg::sample_t asg_a_i,  // Generator A
  input  wire rp_pkg::sample_t asg_b_i,  // Generator B
  input  wire rp_pkg::sample_t pid_a_i,  // Regulator A
  input  wire rp_pkg::sample_t pid_b_i,  // Regulator B
  output rp_pkg::sample_t      dac_a_o,
  output rp_pkg::sample_t      dac_b_o
);

  rp_pkg::mix_sum_t sum_a;
  rp_pkg::mix_sum_t sum_b;

  // Clamp to 8191 / -8192 when the guard bit disagrees with the MSB
  function automatic rp_pkg::sample_t saturate(input rp_pkg::mix_sum_t s);
    logic sgn;
    sgn = s[rp_pkg::SMP_W];  // True sign of the sum
    if (s[rp_pkg::SMP_W] ^ s[rp_pkg::SMP_W-1]) begin
      return {sgn, {(rp_pkg::SMP_W-1){~sgn}}};  // Overflow
    end
    return s[rp_pkg::SMP_W-1:0];  // In range
  endfunction

  // ----------------------------------------------------------
  // Sum, sign-extended to 15 bits by context
  // ----------------------------------------------------------
  assign sum_a = asg_a_i + pid_a_i;
  assign sum_b = asg_b_i + pid_b_i;

  // ----------------------------------------------------------
  // Saturation, purely combinational
  // ----------------------------------------------------------
  assign dac_a_o = saturate(sum_a);
  assign dac_b_o = saturate(sum_b);

endmodule

`default_nettype wire

// File: src/adc_frontend.sv
// ADC capture for both channels
// Pin word to two's complement, digital loopback select, sample register

`timescale 1ns/10ps
`default_nettype none

module adc_frontend (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::adc_pins_t adc_dat_a_i,     // Raw pins CH A
  input  wire rp_pkg::adc_pins_t adc_dat_b_i,     // Raw pins CH B
  input  wire rp_pkg::sample_t   dac_a_i,         // Saturated DAC value A
  input  wire rp_pkg::sample_t   dac_b_i,         // Saturated DAC value B
  input  wire                    digital_loop_i,  // Loopback on
  output rp_pkg::sample_t        adc_a_o,
  output rp_pkg::sample_t        adc_b_o
);

  localparam int LSB = rp_pkg::PIN_W - rp_pkg::SMP_W;  // Reserved pin bits

  rp_pkg::sample_t conv_a;  // Converted pin value
  rp_pkg::sample_t conv_b;
  rp_pkg::sample_t next_a;  // After loopback mux
  rp_pkg::sample_t next_b;

  // ----------------------------------------------------------
  // Conversion, top 14 pin bits only
  // ----------------------------------------------------------
  assign conv_a = rp_pkg::slope_flip(adc_dat_a_i[rp_pkg::PIN_W-1:LSB]);
  assign conv_b = rp_pkg::slope_flip(adc_dat_b_i[rp_pkg::PIN_W-1:LSB]);

  // Loopback replaces the sampled pins
  assign next_a = digital_loop_i ? dac_a_i : conv_a;
  assign next_b = digital_loop_i ? dac_b_i : conv_b;

  // ----------------------------------------------------------
  // Sample registers, latency 1
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= next_a;
      adc_b_o <= next_b;
    end
  end

endmodule

`default_nettype wire

// File: src/dac_output.sv
// DAC output stage for both channels
// RadioBox override, back to negative slope, output registers

`timescale 1ns/10ps
`default_nettype none

module dac_output (
  input  wire                   adc_clk,
  input  wire                   rst_n_i,
  input  wire rp_pkg::sample_t  dac_a_i,         // Mixed, saturated A
  input  wire rp_pkg::sample_t  dac_b_i,         // Mixed, saturated B
  input  wire rp_pkg::rb_word_t rb_out_a_i,      // RadioBox A, 16 bit
  input  wire rp_pkg::rb_word_t rb_out_b_i,      // RadioBox B, 16 bit
  input  wire                   rb_activated_i,  // Override enable
  output rp_pkg::dac_code_t     dac_dat_a_o,
  output rp_pkg::dac_code_t     dac_dat_b_o
);

  localparam int RB_LSB = rp_pkg::RB_W - rp_pkg::SMP_W;  // Dropped RB bits

  rp_pkg::sample_t sel_a;  // Value heading for the DAC
  rp_pkg::sample_t sel_b;

  // ----------------------------------------------------------
  // Source select
  // ----------------------------------------------------------
  // RadioBox uses its top 14 bits only
  assign sel_a = rb_activated_i ? rb_out_a_i[rp_pkg::RB_W-1:RB_LSB] : dac_a_i;
  assign sel_b = rb_activated_i ? rb_out_b_i[rp_pkg::RB_W-1:RB_LSB] : dac_b_i;

  // ----------------------------------------------------------
  // Output registers, negative slope code
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end else begin
      dac_dat_a_o <= rp_pkg::slope_flip(sel_a);  // Sign kept, rest inverted
      dac_dat_b_o <= rp_pkg::slope_flip(sel_b);
    end
  end

endmodule

`default_nettype wire

// File: src/sys_ctrl.sv
// System bus slave and control registers
// Region decode, housekeeping and RadioBox registers
// ADC readback, registered response, LED multiplexer

`timescale 1ns/10ps
`default_nettype none

module sys_ctrl (
  input  wire                   adc_clk,
  input  wire                   rst_n_i,
  input  wire rp_pkg::sys_req_t sys_req_i,
  output rp_pkg::sys_rsp_t      sys_rsp_o,
  input  wire rp_pkg::sample_t  adc_a_i,         // For RB_ADC readback
  input  wire rp_pkg::sample_t  adc_b_i,
  output logic                  digital_loop_o,
  output logic                  rb_activated_o,
  output rp_pkg::led_t          led_o
);

  logic [rp_pkg::REGION_W-1:0]   region;      // Address bits 22..20
  logic [rp_pkg::REGION_CNT-1:0] region_sel;  // One-hot
  logic [rp_pkg::REGION_LSB-1:0] ofs;         // Offset inside region
  logic                          hk_wen;
  logic                          rb_wen;
  rp_pkg::led_t                  hk_led;      // Housekeeping LED pattern
  rp_pkg::led_t                  rb_led;      // RadioBox LED pattern
  logic                          rb_leds_en;
  rp_pkg::bus_word_t             rd_data;     // Read mux, unregistered

  // ----------------------------------------------------------
  // Region decode
  // ----------------------------------------------------------
  assign region     = sys_req_i.addr[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];
  assign ofs        = sys_req_i.addr[rp_pkg::REGION_LSB-1:0];
  assign region_sel = rp_pkg::REGION_CNT'(1) << region;

  assign hk_wen = sys_req_i.wen & region_sel[rp_pkg::REGION_HK];
  assign rb_wen = sys_req_i.wen & region_sel[rp_pkg::REGION_RB];

  // ----------------------------------------------------------
  // Region 0, housekeeping
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      digital_loop_o <= 1'b0;
      hk_led         <= '0;
    end else if (hk_wen) begin
      case (ofs)
        rp_pkg::HK_LOOP_OFS: digital_loop_o <= sys_req_i.wdata[0];
        rp_pkg::HK_LED_OFS:  hk_led         <= sys_req_i.wdata[rp_pkg::LED_W-1:0];
        default: ;  // ID is read-only, rest ignored
      endcase
    end
  end

  // ----------------------------------------------------------
  // Region 1, RadioBox
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rb_activated_o <= 1'b0;
      rb_leds_en     <= 1'b0;
      rb_led         <= '0;
    end else if (rb_wen) begin
      case (ofs)
        rp_pkg::RB_CTRL_OFS: begin
          rb_activated_o <= sys_req_i.wdata[0];
          rb_leds_en     <= sys_req_i.wdata[1];
        end
        rp_pkg::RB_LED_OFS: rb_led <= sys_req_i.wdata[rp_pkg::LED_W-1:0];
        default: ;  // ADC readback is read-only
      endcase
    end
  end

  // ----------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------
  // Regions 2..7 and unknown offsets fall through as zero
  always_comb begin
    rd_data = '0;
    if (region_sel[rp_pkg::REGION_HK]) begin
      case (ofs)
        rp_pkg::HK_ID_OFS:   rd_data = rp_pkg::HK_ID_VALUE;
        rp_pkg::HK_LOOP_OFS: rd_data = {31'b0, digital_loop_o};
        rp_pkg::HK_LED_OFS:  rd_data = {24'b0, hk_led};
        default:             rd_data = '0;
      endcase
    end else if (region_sel[rp_pkg::REGION_RB]) begin
      case (ofs)
        rp_pkg::RB_CTRL_OFS: rd_data = {30'b0, rb_leds_en, rb_activated_o};
        rp_pkg::RB_LED_OFS:  rd_data = {24'b0, rb_led};
        rp_pkg::RB_ADC_OFS:  rd_data = {2'b00, adc_b_i, 2'b00, adc_a_i};  // Sample at request edge
        default:             rd_data = '0;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Response, one cycle after each strobe
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sys_rsp_o <= '0;
    end else begin
      sys_rsp_o.ack   <= sys_req_i.wen | sys_req_i.ren;  // Every region acks
      sys_rsp_o.rdata <= sys_req_i.ren ? rd_data : '0;   // Zero on writes
    end
  end

  // LED source, RadioBox wins when enabled
  assign led_o = rb_leds_en ? rb_led : hk_led;

endmodule

`default_nettype wire

// File: src/rp_top.sv
// Board top level, single adc_clk domain
// Bus slave and control, ADC capture, DAC mixing and DAC output stage

`timescale 1ns/10ps
`default_nettype none

module rp_top (
  input  wire                   adc_clk,
  input  wire                   rst_n_i,
  // ADC pins
  input  wire rp_pkg::adc_pins_t adc_dat_a_i,
  input  wire rp_pkg::adc_pins_t adc_dat_b_i,
  // Generator and regulator
  input  wire rp_pkg::sample_t  asg_a_i,
  input  wire rp_pkg::sample_t  asg_b_i,
  input  wire rp_pkg::sample_t  pid_a_i,
  input  wire rp_pkg::sample_t  pid_b_i,
  // RadioBox outputs
  input  wire rp_pkg::rb_word_t rb_out_a_i,
  input  wire rp_pkg::rb_word_t rb_out_b_i,
  // System bus
  input  wire rp_pkg::sys_req_t sys_req_i,
  output wire rp_pkg::sys_rsp_t sys_rsp_o,
  // DAC and LEDs
  output wire rp_pkg::dac_code_t dac_dat_a_o,
  output wire rp_pkg::dac_code_t dac_dat_b_o,
  output wire rp_pkg::led_t     led_o
);

  // ----------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------
  wire logic            digital_loop;  // HK -> ADC frontend
  wire logic            rb_activated;  // RB -> DAC output
  wire rp_pkg::sample_t dac_a;         // Saturated mix, to DAC and loopback
  wire rp_pkg::sample_t dac_b;
  wire rp_pkg::sample_t adc_a;         // Samples, back to readback
  wire rp_pkg::sample_t adc_b;

  // Control and bus
  sys_ctrl i_sys_ctrl (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_req_i      (sys_req_i),
    .sys_rsp_o      (sys_rsp_o),
    .adc_a_i        (adc_a),
    .adc_b_i        (adc_b),
    .digital_loop_o (digital_loop),
    .rb_activated_o (rb_activated),
    .led_o          (led_o)
  );

  // ADC capture
  adc_frontend i_adc_frontend (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  // Generator + regulator, combinational
  dac_mixer i_dac_mixer (
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .dac_a_o (dac_a),
    .dac_b_o (dac_b)
  );

  // DAC registers, RadioBox override
  dac_output i_dac_output (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .rb_out_a_i     (rb_out_a_i),
    .rb_out_b_i     (rb_out_b_i),
    .rb_activated_i (rb_activated),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// File: test/rp_top_asserts.sv
// Concurrent checks on the system bus response and reset behavior
// Bound into rp_top

`timescale 1ns/10ps
`default_nettype none

module rp_top_asserts (
  input wire                    adc_clk,
  input wire                    rst_n_i,
  input wire rp_pkg::sys_req_t  sys_req_i,
  input wire rp_pkg::sys_rsp_t  sys_rsp_i,  // DUT response
  input wire rp_pkg::dac_code_t dac_a_i,    // DAC output A
  input wire rp_pkg::dac_code_t dac_b_i     // DAC output B
);

  logic req;  // Any strobe this cycle

  assign req = sys_req_i.wen | sys_req_i.ren;

  // ----------------------------------------------------------
  // Bus response
  // ----------------------------------------------------------
  ack_follows_req: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) req |=> sys_rsp_i.ack
  ) else $error("Bus request not acknowledged on the next cycle");

  // Ack only as an answer to a strobe
  ack_needs_req: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) sys_rsp_i.ack |-> $past(req)
  ) else $error("Ack seen without a request one cycle earlier");

  // ----------------------------------------------------------
  // Reset
  // ----------------------------------------------------------
  reset_quiet: assert property (
    @(posedge adc_clk) !rst_n_i |-> (dac_a_i == '0 && dac_b_i == '0 && !sys_rsp_i.ack)
  ) else $error("DAC outputs or ack not zero while reset is asserted");

endmodule

bind rp_top rp_top_asserts i_asserts (
  .adc_clk   (adc_clk),
  .rst_n_i   (rst_n_i),
  .sys_req_i (sys_req_i),
  .sys_rsp_i (sys_rsp_o),
  .dac_a_i   (dac_dat_a_o),
  .dac_b_i   (dac_dat_b_o)
);

`default_nettype wire

// File: test/rp_top_tb.sv
// Testbench for rp_top
// Clock, reset, LFSR stimulus, bus tasks, reference models
// Comparing process, six tests, watchdog and summary

`timescale 1ns/10ps
`default_nettype none

module rp_top_tb;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DLY  = 2;   // Inputs change after the edge
  localparam int ACK_WAIT   = 8;   // Cycles before an ack counts as lost
  localparam int RST_CYCLES = 8;
  localparam int MIX_N      = 200;
  localparam int RB_N       = 20;
  localparam int ADC_N      = 20;
  localparam int LOOP_N     = 10;
  localparam int BUS_OPS    = 44;  // Register and control accesses rounded up
  localparam int EST_CYCLES = RST_CYCLES + MIX_N + 3 * RB_N + 3 * ADC_N
                              + 4 * LOOP_N + 3 * BUS_OPS;
  localparam int WATCHDOG_CYCLES = 4 * EST_CYCLES;

  logic adc_clk;
  logic rst_n;
  rp_pkg::adc_pins_t adc_dat_a, adc_dat_b;
  rp_pkg::sample_t   asg_a, asg_b, pid_a, pid_b;
  rp_pkg::rb_word_t  rb_a, rb_b;
  rp_pkg::sys_req_t  sys_req;
  rp_pkg::sys_rsp_t  sys_rsp;
  rp_pkg::dac_code_t dac_dat_a, dac_dat_b;
  rp_pkg::led_t      led;

  logic [31:0] lfsr;            // Galois LFSR state
  string       name_q[$];       // Pending checks
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];
  string       cmp_name;
  logic [31:0] cmp_exp, cmp_act;
  string       cur_test;
  int          chk_cnt, err_cnt, chk_base, err_base, n_tests, i;
  rp_pkg::bus_word_t d, rd;
  rp_pkg::dac_code_t exp_a, exp_b;
  rp_pkg::led_t      hk_pat, rb_pat;

  rp_top dut (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .asg_a_i     (asg_a),
    .asg_b_i     (asg_b),
    .pid_a_i     (pid_a),
    .pid_b_i     (pid_b),
    .rb_out_a_i  (rb_a),
    .rb_out_b_i  (rb_b),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .led_o       (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // ----------------------------------------------------------
  // Random numbers and reference models
  // ----------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int k;
    r = '0;
    for (k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};  // One step per bit
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic rp_pkg::sample_t rand_sample();
    logic [31:0] r;
    r = rand_bits(rp_pkg::SMP_W);
    return r[rp_pkg::SMP_W-1:0];
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = rand_bits(16);
    return r[15:0];
  endfunction

  // Sign bit kept and the other 13 inverted
  function automatic rp_pkg::dac_code_t neg_slope(input rp_pkg::sample_t s);
    return s ^ 14'h1fff;
  endfunction

  function automatic rp_pkg::sample_t pin_to_sample(input rp_pkg::adc_pins_t p);
    return p[15:2] ^ 14'h1fff;  // Reserved LSBs dropped
  endfunction

  // Integer sum clamped to the 14-bit range
  function automatic rp_pkg::sample_t mix_ref(input rp_pkg::sample_t g, input rp_pkg::sample_t r);
    int sum;
    sum = int'(g) + int'(r);
    if (sum > 8191) sum = 8191;
    else if (sum < -8192) sum = -8192;
    return sum[13:0];
  endfunction

  function automatic rp_pkg::bus_word_t reg_addr(input int region, input logic [19:0] ofs);
    rp_pkg::bus_word_t a;
    a = '0;
    a[22:20] = region[2:0];  // Region field
    a[19:0]  = ofs;
    return a;
  endfunction

  // ----------------------------------------------------------
  // Drive, bus and check tasks
  // ----------------------------------------------------------
  task automatic step();
    @(posedge adc_clk);
    #(DRIVE_DLY);
  endtask

  task automatic drive_mix(input rp_pkg::sample_t ga, input rp_pkg::sample_t pa,
                           input rp_pkg::sample_t gb, input rp_pkg::sample_t pb);
    asg_a = ga;
    pid_a = pa;
    asg_b = gb;
    pid_b = pb;
  endtask

  task automatic expect_eq(input string label, input logic [31:0] e, input logic [31:0] a);
    name_q.push_back({cur_test, " ", label});
    exp_q.push_back(e);
    act_q.push_back(a);
  endtask

  task automatic bus_write(input rp_pkg::bus_word_t addr, input rp_pkg::bus_word_t data);
    int n;
    sys_req.addr  = addr;
    sys_req.wdata = data;
    sys_req.wen   = 1'b1;  // One-cycle strobe
    step();
    sys_req.wen = 1'b0;
    n = 0;
    while (!sys_rsp.ack && n < ACK_WAIT) begin
      step();
      n++;
    end
    assert (sys_rsp.ack) else begin
      $display("No acknowledge for the write to address %h", addr);
      err_cnt++;
    end
  endtask

  task automatic bus_read(input rp_pkg::bus_word_t addr, output rp_pkg::bus_word_t data);
    int n;
    sys_req.addr = addr;
    sys_req.ren  = 1'b1;
    step();
    sys_req.ren = 1'b0;
    n = 0;
    while (!sys_rsp.ack && n < ACK_WAIT) begin
      step();
      n++;
    end
    assert (sys_rsp.ack) else begin
      $display("No acknowledge for the read of address %h", addr);
      err_cnt++;
    end
    data = sys_rsp.rdata;
  endtask

  task automatic read_check(input string label, input rp_pkg::bus_word_t addr,
                            input rp_pkg::bus_word_t e);
    rp_pkg::bus_word_t got;
    bus_read(addr, got);
    expect_eq(label, e, got);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    chk_base = chk_cnt;
    err_base = err_cnt;
  endtask

  task automatic end_test();
    step();  // Comparing process drains at this edge
    $display("%s: %0d checks, %0d errors", cur_test, chk_cnt - chk_base, err_cnt - err_base);
    n_tests++;
  endtask

  // Comparing process that runs at the edge while stimulus waits
  always @(posedge adc_clk) begin
    while (exp_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      chk_cnt++;
      assert (cmp_act === cmp_exp) else begin
        $display("Error %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
        err_cnt++;
      end
    end
  end

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  initial begin
    lfsr = 32'h13b7_1327;
    rst_n = 1'b0;
    sys_req = '0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    drive_mix('0, '0, '0, '0);
    rb_a = '0;
    rb_b = '0;
    chk_cnt = 0;
    err_cnt = 0;
    n_tests = 0;

    start_test("reset");
    repeat (RST_CYCLES) step();
    expect_eq("dac a", 32'h0, 32'(dac_dat_a));  // Still in reset
    expect_eq("dac b", 32'h0, 32'(dac_dat_b));
    expect_eq("leds", 32'h0, 32'(led));
    expect_eq("ack", 32'h0, 32'(sys_rsp.ack));
    rst_n = 1'b1;
    step();
    read_check("id", reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_ID_OFS), rp_pkg::HK_ID_VALUE);
    end_test();

    start_test("registers");
    d = rand_bits(32) | 32'h1;  // Bit 0 away from its reset value
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_OFS), d);
    read_check("hk_loop", reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_OFS), {31'b0, d[0]});
    d = rand_bits(32);
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LED_OFS), d);
    read_check("hk_led", reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LED_OFS), {24'b0, d[7:0]});
    d = rand_bits(32) | 32'h3;  // Both control bits away from reset
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), d);
    read_check("rb_ctrl", reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), {30'b0, d[1:0]});
    d = rand_bits(32);
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_LED_OFS), d);
    read_check("rb_led", reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_LED_OFS), {24'b0, d[7:0]});
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_ID_OFS), 32'h0);  // ID is read-only
    read_check("id kept", reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_ID_OFS), rp_pkg::HK_ID_VALUE);
    for (i = 2; i < rp_pkg::REGION_CNT; i++) begin
      read_check("empty region", reg_addr(i, 20'h0_0004), 32'h0);
    end
    read_check("hk unknown", reg_addr(rp_pkg::REGION_HK, 20'h0_000c), 32'h0);
    read_check("rb unknown", reg_addr(rp_pkg::REGION_RB, 20'h0_0010), 32'h0);
    end_test();

    start_test("mixing");
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), 32'h0);  // RadioBox off
    for (i = 0; i < MIX_N; i++) begin
      case (i)
        0: drive_mix(14'sh1fff, 14'sh1fff, 14'sh2000, 14'sh2000);  // A high, B low clamp
        1: drive_mix(14'sh2000, 14'sh3fff, 14'sh1fff, 14'sh0001);  // A low, B high clamp
        2: drive_mix(14'sh1fff, 14'sh2000, 14'sh0000, 14'sh0000);
        default: drive_mix(rand_sample(), rand_sample(), rand_sample(), rand_sample());
      endcase
      exp_a = neg_slope(mix_ref(asg_a, pid_a));
      exp_b = neg_slope(mix_ref(asg_b, pid_b));
      step();
      expect_eq("dac a", 32'(exp_a), 32'(dac_dat_a));
      expect_eq("dac b", 32'(exp_b), 32'(dac_dat_b));
    end
    end_test();

    start_test("radiobox");
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), 32'h1);
    for (i = 0; i < RB_N; i++) begin
      drive_mix(rand_sample(), rand_sample(), rand_sample(), rand_sample());
      rb_a = rand_word();
      rb_b = rand_word();
      step();
      expect_eq("rb a", 32'(neg_slope(rb_a[15:2])), 32'(dac_dat_a));  // Top 14 bits
      expect_eq("rb b", 32'(neg_slope(rb_b[15:2])), 32'(dac_dat_b));
    end
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), 32'h0);
    step();  // Output register picks up the cleared flag
    expect_eq("mix a", 32'(neg_slope(mix_ref(asg_a, pid_a))), 32'(dac_dat_a));
    expect_eq("mix b", 32'(neg_slope(mix_ref(asg_b, pid_b))), 32'(dac_dat_b));
    end_test();

    start_test("adc");
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_OFS), 32'h0);
    for (i = 0; i < ADC_N; i++) begin
      adc_dat_a = rand_word();
      adc_dat_b = rand_word();
      step();  // Settled cycle
      bus_read(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_ADC_OFS), rd);
      expect_eq("pins", {2'b00, pin_to_sample(adc_dat_b), 2'b00, pin_to_sample(adc_dat_a)}, rd);
    end
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_OFS), 32'h1);
    for (i = 0; i < LOOP_N; i++) begin
      drive_mix(rand_sample(), rand_sample(), rand_sample(), rand_sample());
      step();
      bus_read(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_ADC_OFS), rd);
      expect_eq("loopback", {2'b00, mix_ref(asg_b, pid_b), 2'b00, mix_ref(asg_a, pid_a)}, rd);
    end
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_OFS), 32'h0);
    end_test();

    start_test("leds");
    d = rand_bits(32);
    hk_pat = d[7:0];
    bus_write(reg_addr(rp_pkg::REGION_HK, rp_pkg::HK_LED_OFS), d);
    d = rand_bits(32);
    rb_pat = d[7:0];
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_LED_OFS), d);
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), 32'h0);
    expect_eq("hk pattern", 32'(hk_pat), 32'(led));
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), 32'h2);  // rb_leds_en
    expect_eq("rb pattern", 32'(rb_pat), 32'(led));
    bus_write(reg_addr(rp_pkg::REGION_RB, rp_pkg::RB_CTRL_OFS), 32'h0);
    expect_eq("hk again", 32'(hk_pat), 32'(led));
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog at four times the estimated run length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rp_top.f
src/rp_pkg.sv
src/dac_mixer.sv
src/adc_frontend.sv
src/dac_output.sv
src/sys_ctrl.sv
src/rp_top.sv
test/rp_top_asserts.sv
test/rp_top_tb.sv

// File: Makefile
# Verilator flow for the rp_top testbench
# Pass or fail comes from the simulator output, no log file kept

TOP := rp_top_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module $(TOP) -f rp_top.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module rp_top -f rp_top.f

clean:
	rm -rf obj_dir
